//--- color_match.sv
`timescale 1ns/100ps
`include "pre_consts.svh"

module color_match (
    input  logic                   i_pre_clk,
    input  logic                   i_rst_n,
    input  logic                   i_vsync,
    input  logic                   i_de,
    input  pre_pkg::pixel_u        i_data,
    input  pre_pkg::chan_t         i_a_r0,
    input  pre_pkg::chan_t         i_a_g0,
    input  pre_pkg::chan_t         i_a_b0,
    input  pre_pkg::cfg_byte_t     i_a_err,
    input  pre_pkg::cfg_byte_t     i_a_vmin,
    input  pre_pkg::cfg_byte_t     i_a_vmax,
    input  pre_pkg::chan_t         i_b_r0,
    input  pre_pkg::chan_t         i_b_g0,
    input  pre_pkg::chan_t         i_b_b0,
    input  pre_pkg::cfg_byte_t     i_b_err,
    input  pre_pkg::cfg_byte_t     i_b_vmin,
    input  pre_pkg::cfg_byte_t     i_b_vmax,
    input  logic                   i_process,
    output logic                   o_valid,
    output pre_pkg::pixel_u        o_data,
    output logic                   o_match_valid,
    output logic                   o_match_wb
);

    function automatic pre_pkg::chan_t abs_diff(input pre_pkg::chan_t x,
                                                input pre_pkg::chan_t y);
        return (x > y) ? x - y : y - x;
    endfunction

    pre_pkg::chan_t  r_c, g_c, b_c, v_c;

    logic            valid_1;
    logic [2:0]      a_ok_1, b_ok_1;   // {r, g, b} within tolerance
    pre_pkg::chan_t  v_1;
    pre_pkg::pixel_u data_1;

    logic            match_a, match_b;
    logic            valid_2;
    logic            wb_2;
    pre_pkg::pixel_u data_2;

    // 565 -> 6 bit channels
    assign r_c = {i_data.rgb.r, 1'b0};
    assign g_c = i_data.rgb.g;
    assign b_c = {i_data.rgb.b, 1'b0};

    always_comb begin
        v_c = r_c;                       // brightness = max channel
        if (g_c > v_c) v_c = g_c;
        if (b_c > v_c) v_c = b_c;
    end

    always_ff @(posedge i_pre_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_1 <= 1'b0;
            valid_2 <= 1'b0;
        end else begin
            valid_1 <= i_de & ~i_vsync;
            valid_2 <= valid_1 & ~i_vsync;   // frame sync flushes in-flight
        end
    end

    // stage 1
    always_ff @(posedge i_pre_clk) begin
        a_ok_1[2] <= abs_diff(r_c, i_a_r0) <= i_a_err;
        a_ok_1[1] <= abs_diff(g_c, i_a_g0) <= i_a_err;
        a_ok_1[0] <= abs_diff(b_c, i_a_b0) <= i_a_err;
        b_ok_1[2] <= abs_diff(r_c, i_b_r0) <= i_b_err;
        b_ok_1[1] <= abs_diff(g_c, i_b_g0) <= i_b_err;
        b_ok_1[0] <= abs_diff(b_c, i_b_b0) <= i_b_err;
        v_1       <= v_c;
        data_1    <= i_data;
    end

    assign match_a = (&a_ok_1) && (v_1 >= i_a_vmin) && (v_1 <= i_a_vmax);
    assign match_b = (&b_ok_1) && (v_1 >= i_b_vmin) && (v_1 <= i_b_vmax);

    // stage 2
    always_ff @(posedge i_pre_clk) begin
        wb_2 <= match_a | match_b;
        if (i_process && !(match_a || match_b))
            data_2.raw <= '0;            // blank unmatched
        else
            data_2 <= data_1;
    end

    assign o_valid       = valid_2;
    assign o_data        = data_2;
    assign o_match_valid = valid_2;
    assign o_match_wb    = wb_2;

endmodule

//--- list.f
+incdir+.
pre_pkg.sv
pre_cfg_regs.sv
color_match.sv
wb_erode.sv
pre_top.sv
tb_pre_top.sv

//--- pre_cfg_regs.sv
`timescale 1ns/100ps
`include "pre_consts.svh"

module pre_cfg_regs (
    input  logic                   i_pre_clk,
    input  logic                   i_rst_n,
    input  logic                   i_cfg_we,
    input  logic [`CFG_AW-1:0]     i_cfg_addr,
    input  pre_pkg::cfg_byte_t     i_cfg_wdata,
    output pre_pkg::cfg_byte_t     o_cfg_rdata,
    output pre_pkg::chan_t         o_a_r0,
    output pre_pkg::chan_t         o_a_g0,
    output pre_pkg::chan_t         o_a_b0,
    output pre_pkg::cfg_byte_t     o_a_err,
    output pre_pkg::cfg_byte_t     o_a_vmin,
    output pre_pkg::cfg_byte_t     o_a_vmax,
    output pre_pkg::chan_t         o_b_r0,
    output pre_pkg::chan_t         o_b_g0,
    output pre_pkg::chan_t         o_b_b0,
    output pre_pkg::cfg_byte_t     o_b_err,
    output pre_pkg::cfg_byte_t     o_b_vmin,
    output pre_pkg::cfg_byte_t     o_b_vmax,
    output pre_pkg::cfg_byte_t     o_min_run,
    output logic                   o_process
);

    localparam pre_pkg::cfg_byte_t RST_VAL [`CFG_NUM] = '{
        `RST_A_R0, `RST_A_G0, `RST_A_B0, `RST_A_ERR, `RST_A_VMIN, `RST_A_VMAX,
        `RST_B_R0, `RST_B_G0, `RST_B_B0, `RST_B_ERR, `RST_B_VMIN, `RST_B_VMAX,
        `RST_MODE, `RST_MIN_RUN
    };

    pre_pkg::cfg_byte_t regs [`CFG_NUM];
    logic               addr_ok;

    assign addr_ok = (i_cfg_addr < `CFG_NUM);   // 14 and 15 unimplemented

    always_ff @(posedge i_pre_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs <= RST_VAL;
        end else if (i_cfg_we && addr_ok) begin
            regs[i_cfg_addr] <= i_cfg_wdata;
        end
    end

    assign o_cfg_rdata = addr_ok ? regs[i_cfg_addr] : '0;

    // colour bytes only carry 6 bits into the datapath
    assign o_a_r0    = regs[`REG_A_R0][`CH_W-1:0];
    assign o_a_g0    = regs[`REG_A_G0][`CH_W-1:0];
    assign o_a_b0    = regs[`REG_A_B0][`CH_W-1:0];
    assign o_a_err   = regs[`REG_A_ERR];
    assign o_a_vmin  = regs[`REG_A_VMIN];
    assign o_a_vmax  = regs[`REG_A_VMAX];
    assign o_b_r0    = regs[`REG_B_R0][`CH_W-1:0];
    assign o_b_g0    = regs[`REG_B_G0][`CH_W-1:0];
    assign o_b_b0    = regs[`REG_B_B0][`CH_W-1:0];
    assign o_b_err   = regs[`REG_B_ERR];
    assign o_b_vmin  = regs[`REG_B_VMIN];
    assign o_b_vmax  = regs[`REG_B_VMAX];
    assign o_min_run = regs[`REG_MIN_RUN];
    assign o_process = regs[`REG_MODE][0];

endmodule

//--- pre_consts.svh
`ifndef PRE_CONSTS_SVH
`define PRE_CONSTS_SVH

`define PIX_W           16
`define CH_W            6
`define CFG_AW          4
`define CFG_NUM         14

// parameter byte map
`define REG_A_R0        4'd0
`define REG_A_G0        4'd1
`define REG_A_B0        4'd2
`define REG_A_ERR       4'd3
`define REG_A_VMIN      4'd4
`define REG_A_VMAX      4'd5
`define REG_B_R0        4'd6
`define REG_B_G0        4'd7
`define REG_B_B0        4'd8
`define REG_B_ERR       4'd9
`define REG_B_VMIN      4'd10
`define REG_B_VMAX      4'd11
`define REG_MODE        4'd12   // bit 0: processed output
`define REG_MIN_RUN     4'd13

`define RST_A_R0        8'd60   // near white
`define RST_A_G0        8'd60
`define RST_A_B0        8'd60
`define RST_A_ERR       8'd8
`define RST_A_VMIN      8'd40
`define RST_A_VMAX      8'd63
`define RST_B_R0        8'd60   // near yellow
`define RST_B_G0        8'd56
`define RST_B_B0        8'd10
`define RST_B_ERR       8'd8
`define RST_B_VMIN      8'd30
`define RST_B_VMAX      8'd63
`define RST_MODE        8'd1
`define RST_MIN_RUN     8'd3

`endif

//--- pre_pkg.sv
`include "pre_consts.svh"

package pre_pkg;

    // rgb565 word, msb first
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // same pixel word, whole or by field
    typedef union packed {
        logic [`PIX_W-1:0] raw;
        rgb565_t           rgb;
    } pixel_u;

    typedef logic [`CH_W-1:0] chan_t;

    typedef logic [7:0] cfg_byte_t;

endpackage

//--- pre_top.sv
`timescale 1ns/100ps
`include "pre_consts.svh"

module pre_top (
    input  logic                   i_pre_clk,
    input  logic                   i_rst_n,
    input  logic                   i_vsync,
    input  logic                   i_de,
    input  pre_pkg::pixel_u        i_data,
    input  logic                   i_cfg_we,
    input  logic [`CFG_AW-1:0]     i_cfg_addr,
    input  pre_pkg::cfg_byte_t     i_cfg_wdata,
    output pre_pkg::cfg_byte_t     o_cfg_rdata,
    output logic                   o_valid,
    output pre_pkg::pixel_u        o_data,
    output logic                   o_wb_valid,
    output logic                   o_wb
);

    pre_pkg::chan_t      a_r0, a_g0, a_b0;
    pre_pkg::chan_t      b_r0, b_g0, b_b0;
    pre_pkg::cfg_byte_t  a_err, a_vmin, a_vmax;
    pre_pkg::cfg_byte_t  b_err, b_vmin, b_vmax;
    pre_pkg::cfg_byte_t  min_run;
    logic                process;
    logic                match_valid;
    logic                match_wb;

    pre_cfg_regs u_pre_cfg_regs (
        .i_pre_clk    (i_pre_clk   ),
        .i_rst_n      (i_rst_n     ),
        .i_cfg_we     (i_cfg_we    ),
        .i_cfg_addr   (i_cfg_addr  ),
        .i_cfg_wdata  (i_cfg_wdata ),
        .o_cfg_rdata  (o_cfg_rdata ),
        .o_a_r0       (a_r0        ),
        .o_a_g0       (a_g0        ),
        .o_a_b0       (a_b0        ),
        .o_a_err      (a_err       ),
        .o_a_vmin     (a_vmin      ),
        .o_a_vmax     (a_vmax      ),
        .o_b_r0       (b_r0        ),
        .o_b_g0       (b_g0        ),
        .o_b_b0       (b_b0        ),
        .o_b_err      (b_err       ),
        .o_b_vmin     (b_vmin      ),
        .o_b_vmax     (b_vmax      ),
        .o_min_run    (min_run     ),
        .o_process    (process     )
    );

    // delay = 2
    color_match u_color_match (
        .i_pre_clk     (i_pre_clk  ),
        .i_rst_n       (i_rst_n    ),
        .i_vsync       (i_vsync    ),
        .i_de          (i_de       ),
        .i_data        (i_data     ),
        .i_a_r0        (a_r0       ),
        .i_a_g0        (a_g0       ),
        .i_a_b0        (a_b0       ),
        .i_a_err       (a_err      ),
        .i_a_vmin      (a_vmin     ),
        .i_a_vmax      (a_vmax     ),
        .i_b_r0        (b_r0       ),
        .i_b_g0        (b_g0       ),
        .i_b_b0        (b_b0       ),
        .i_b_err       (b_err      ),
        .i_b_vmin      (b_vmin     ),
        .i_b_vmax      (b_vmax     ),
        .i_process     (process    ),
        .o_valid       (o_valid    ),
        .o_data        (o_data     ),
        .o_match_valid (match_valid),
        .o_match_wb    (match_wb   )
    );

    // delay = 1
    wb_erode u_wb_erode (
        .i_pre_clk  (i_pre_clk  ),
        .i_rst_n    (i_rst_n    ),
        .i_vsync    (i_vsync    ),
        .i_valid    (match_valid),
        .i_wb       (match_wb   ),
        .i_min_run  (min_run    ),
        .o_valid    (o_wb_valid ),
        .o_wb       (o_wb       )
    );

endmodule

//--- tb_pre_ref.svh
`ifndef TB_PRE_REF_SVH
`define TB_PRE_REF_SVH

// galois form, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

function automatic int chan_gap(input int x, input int y);
    return (x > y) ? x - y : y - x;
endfunction

// match against one reference colour
function automatic logic colour_hit(input pre_pkg::pixel_u p, input pre_pkg::cfg_byte_t r0,
        input pre_pkg::cfg_byte_t g0, input pre_pkg::cfg_byte_t b0,
        input pre_pkg::cfg_byte_t err, input pre_pkg::cfg_byte_t vmin,
        input pre_pkg::cfg_byte_t vmax);
    int r;
    int g;
    int b;
    int v;
    r = 2 * int'(p.rgb.r);             // 5 bit fields gain a zero lsb
    g = int'(p.rgb.g);
    b = 2 * int'(p.rgb.b);
    v = (r > g) ? r : g;
    if (b > v)
        v = b;
    return chan_gap(r, int'(r0[5:0])) <= int'(err) && chan_gap(g, int'(g0[5:0])) <= int'(err)
        && chan_gap(b, int'(b0[5:0])) <= int'(err) && v >= int'(vmin) && v <= int'(vmax);
endfunction

function automatic pre_pkg::pixel_u expected_pixel(input pre_pkg::pixel_u p,
        input logic match, input logic process);
    pre_pkg::pixel_u q;
    q = p;
    if (process && !match)
        q.raw = '0;
    return q;
endfunction

// run length including this sample, saturating
function automatic logic [7:0] next_run(input logic [7:0] run, input logic wb);
    if (!wb)
        return 8'd0;
    return (run == 8'hff) ? run : run + 8'd1;
endfunction

`endif

//--- tb_pre_top.sv
`timescale 1ns/100ps
`include "pre_consts.svh"

module tb_pre_top;

    logic i_pre_clk, i_rst_n, i_vsync, i_de, i_cfg_we, o_valid, o_wb_valid, o_wb;
    logic [`CFG_AW-1:0] i_cfg_addr;
    pre_pkg::pixel_u    i_data, o_data;
    pre_pkg::cfg_byte_t i_cfg_wdata, o_cfg_rdata;

    pre_pkg::cfg_byte_t rst_vals [`CFG_NUM];
    pre_pkg::cfg_byte_t cfg_copy [`CFG_NUM];     // what the DUT registers should hold
    pre_pkg::pixel_u    exp_pix_q [$];
    logic               exp_wb_q [$];
    logic [15:0]        lfsr_state;
    logic [7:0]         ref_run;
    int accepted, pix_seen, wb_seen, cfg_errs, pix_errs, mask_errs, flow_errs;
    int pix_dropped, wb_dropped;

    `include "tb_pre_ref.svh"

    pre_top pre_top_i (.*);

    initial begin
        i_pre_clk = 1'b0;
        forever #50 i_pre_clk = ~i_pre_clk;
    end

    function automatic logic [15:0] draw_bits(input int n);
        logic [15:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [5:0] near_chan(input logic [5:0] base);
        int c;
        c = int'(base) + int'(draw_bits(4)) - 8;
        return (c < 0) ? 6'd0 : (c > 63) ? 6'd63 : 6'(c);
    endfunction

    // mostly pixels close to colour a or b, a quarter fully random
    function automatic pre_pkg::pixel_u make_pixel();
        pre_pkg::pixel_u p;
        logic [1:0] sel;
        logic [5:0] r;
        logic [5:0] b;
        int base;
        sel = 2'(draw_bits(2));
        if (sel == 2'd3) begin
            p.raw = draw_bits(16);
        end else begin
            base = sel[0] ? int'(`REG_B_R0) : int'(`REG_A_R0);
            r = near_chan(cfg_copy[base][5:0]);
            p.rgb.g = near_chan(cfg_copy[base + 1][5:0]);
            b = near_chan(cfg_copy[base + 2][5:0]);
            p.rgb.r = r[5:1];
            p.rgb.b = b[5:1];
        end
        return p;
    endfunction

    task push_expected(input pre_pkg::pixel_u p);
        logic m;
        m = colour_hit(p, cfg_copy[0], cfg_copy[1], cfg_copy[2], cfg_copy[3], cfg_copy[4],
                       cfg_copy[5])
            || colour_hit(p, cfg_copy[6], cfg_copy[7], cfg_copy[8], cfg_copy[9], cfg_copy[10],
                          cfg_copy[11]);
        exp_pix_q.push_back(expected_pixel(p, m, cfg_copy[`REG_MODE][0]));
        ref_run = next_run(ref_run, m);
        exp_wb_q.push_back(m && (ref_run >= cfg_copy[`REG_MIN_RUN]));
        accepted++;
    endtask

    task check_pixel(input pre_pkg::pixel_u exp, input pre_pkg::pixel_u act);
        if (act.raw !== exp.raw) begin
            pix_errs++;
            $display("Error at %0t ns: o_data %h, expected %h", $time, act.raw, exp.raw);
        end
    endtask

    task check_mask(input logic exp, input logic act);
        if (act !== exp) begin
            mask_errs++;
            $display("Error at %0t ns: o_wb %b, expected %b", $time, act, exp);
        end
    endtask

    task check_cfg(input pre_pkg::cfg_byte_t exp, input pre_pkg::cfg_byte_t act, input int a);
        if (act !== exp) begin
            cfg_errs++;
            $display("Error at %0t ns: register %0d reads %h, expected %h", $time, a, act, exp);
        end
    endtask

    task write_reg(input int a, input pre_pkg::cfg_byte_t d);
        @(posedge i_pre_clk);
        i_cfg_we    <= 1'b1;
        i_cfg_addr  <= a[`CFG_AW-1:0];
        i_cfg_wdata <= d;
        @(posedge i_pre_clk);
        i_cfg_we <= 1'b0;
        if (a < `CFG_NUM)
            cfg_copy[a] = d;
    endtask

    task read_check(input int a, input pre_pkg::cfg_byte_t exp);
        @(posedge i_pre_clk);
        i_cfg_addr <= a[`CFG_AW-1:0];
        @(negedge i_pre_clk);                    // readback is combinational
        check_cfg(exp, o_cfg_rdata, a);
    endtask

    task run_stream(input int cycles, input logic gaps);
        pre_pkg::pixel_u p;
        logic de;
        int k;
        for (k = 0; k < cycles; k++) begin
            @(posedge i_pre_clk);
            p = make_pixel();
            de = !gaps || (2'(draw_bits(2)) != 2'd0);
            i_de   <= de;
            i_data <= p;
            if (de)
                push_expected(p);
        end
        @(posedge i_pre_clk);
        i_de <= 1'b0;
    endtask

    task wait_drain();
        int t;
        t = 0;
        while ((exp_pix_q.size() != 0 || exp_wb_q.size() != 0) && t < 20) begin
            @(posedge i_pre_clk);
            t++;
        end
        if (exp_pix_q.size() != 0 || exp_wb_q.size() != 0) begin
            flow_errs++;
            $display("timed out at %0t ns waiting for %0d pixels and %0d mask bits",
                     $time, exp_pix_q.size(), exp_wb_q.size());
        end
        repeat (3) @(posedge i_pre_clk);         // room for stray strobes
    endtask

    // pixels offered during the pulse must vanish, and so must those in flight
    task pulse_vsync(input int cycles);
        pre_pkg::pixel_u p;
        int k;
        for (k = 0; k < 4; k++) begin            // pipeline full when the pulse starts
            @(posedge i_pre_clk);
            p = make_pixel();
            i_de   <= 1'b1;
            i_data <= p;
            push_expected(p);
        end
        @(posedge i_pre_clk);
        i_vsync <= 1'b1;
        i_data  <= make_pixel();
        for (k = 0; k < cycles; k++) begin
            @(posedge i_pre_clk);
            if (k == 0) begin                    // first edge that sees vsync high
                pix_dropped += exp_pix_q.size();
                wb_dropped  += exp_wb_q.size();
                exp_pix_q.delete();
                exp_wb_q.delete();
                ref_run = 8'd0;
            end
            i_data <= make_pixel();
        end
        i_vsync <= 1'b0;
        i_de    <= 1'b0;
    endtask

    always @(negedge i_pre_clk) begin
        if (i_rst_n && o_valid) begin
            pix_seen++;
            if (exp_pix_q.size() == 0) begin
                flow_errs++;
                $display("o_valid pulsed at %0t ns with no pixel expected", $time);
            end else begin
                check_pixel(exp_pix_q.pop_front(), o_data);
            end
        end
        if (i_rst_n && o_wb_valid) begin
            wb_seen++;
            if (exp_wb_q.size() == 0) begin
                flow_errs++;
                $display("o_wb_valid pulsed at %0t ns with no mask bit expected", $time);
            end else begin
                check_mask(exp_wb_q.pop_front(), o_wb);
            end
        end
    end

    initial begin
        int a;
        int runs [4];
        pre_pkg::cfg_byte_t d;
        rst_vals = '{`RST_A_R0, `RST_A_G0, `RST_A_B0, `RST_A_ERR, `RST_A_VMIN, `RST_A_VMAX,
                     `RST_B_R0, `RST_B_G0, `RST_B_B0, `RST_B_ERR, `RST_B_VMIN, `RST_B_VMAX,
                     `RST_MODE, `RST_MIN_RUN};
        runs = '{0, 1, 2, 5};
        cfg_copy = rst_vals;
        lfsr_state = 16'd48625;
        ref_run = 8'd0;
        {accepted, pix_seen, wb_seen} = '0;
        {cfg_errs, pix_errs, mask_errs, flow_errs} = '0;
        pix_dropped = 0;
        wb_dropped = 0;
        i_rst_n = 1'b0;
        i_vsync = 1'b0;
        i_de = 1'b0;
        i_data = '0;
        i_cfg_we = 1'b0;
        i_cfg_addr = '0;
        i_cfg_wdata = '0;
        repeat (4) @(posedge i_pre_clk);
        i_rst_n <= 1'b1;

        for (a = 0; a < `CFG_NUM; a++)
            read_check(a, rst_vals[a]);
        read_check(14, 8'h00);
        read_check(15, 8'h00);
        for (a = 0; a < 16; a++) begin
            d = 8'(draw_bits(8));
            write_reg(a, d);
            read_check(a, (a < `CFG_NUM) ? d : 8'h00);
        end
        for (a = 0; a < `CFG_NUM; a++)
            write_reg(a, rst_vals[a]);

        run_stream(200, 1'b1);                   // processed mode
        wait_drain();
        write_reg(`REG_MODE, 8'd0);              // raw pass-through
        run_stream(150, 1'b1);
        wait_drain();
        write_reg(`REG_MODE, 8'd1);
        for (a = 0; a < 4; a++) begin
            write_reg(`REG_MIN_RUN, 8'(runs[a]));
            run_stream(100, 1'b1);
            wait_drain();
        end
        run_stream(40, 1'b1);
        wait_drain();
        pulse_vsync(3);
        run_stream(40, 1'b1);
        wait_drain();
        run_stream(300, 1'b0);                   // back to back
        wait_drain();

        if (pix_seen != accepted - pix_dropped || wb_seen != accepted - wb_dropped) begin
            flow_errs++;
            $display("Error at %0t ns: %0d pixel and %0d mask strobes, expected %0d and %0d",
                     $time, pix_seen, wb_seen, accepted - pix_dropped, accepted - wb_dropped);
        end
        $display("errors: cfg %0d, pixel %0d, mask %0d, flow %0d",
                 cfg_errs, pix_errs, mask_errs, flow_errs);
        if (cfg_errs + pix_errs + mask_errs + flow_errs == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- wb_erode.sv
`timescale 1ns/100ps

module wb_erode (
    input  logic                   i_pre_clk,
    input  logic                   i_rst_n,
    input  logic                   i_vsync,
    input  logic                   i_valid,
    input  logic                   i_wb,
    input  pre_pkg::cfg_byte_t     i_min_run,
    output logic                   o_valid,
    output logic                   o_wb
);

    logic [7:0] run_cnt;
    logic [7:0] run_next;

    // count includes the current sample
    always_comb begin
        if (!i_wb)
            run_next = 8'd0;
        else if (run_cnt == 8'hff)
            run_next = run_cnt;          // saturate
        else
            run_next = run_cnt + 8'd1;
    end

    always_ff @(posedge i_pre_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cnt <= 8'd0;
            o_valid <= 1'b0;
            o_wb    <= 1'b0;
        end else if (i_vsync) begin
            run_cnt <= 8'd0;
            o_valid <= 1'b0;
            o_wb    <= 1'b0;
        end else begin
            if (i_valid)
                run_cnt <= run_next;
            o_valid <= i_valid;
            o_wb    <= i_valid & i_wb & (run_next >= i_min_run);
        end
    end

endmodule
